// ==== Bender.yml ====
package:
  name: mailbox

sources:
  - mailbox_pkg.sv
  - cdc_export.sv
  - cdc_import.sv
  - mailbox_regs.sv
  - mailbox_top.sv
  - target: test
    files:
      - tb_clock.sv
      - mailbox_tb.sv

// ==== cdc_export.sv ====
`timescale 1ns/1ns

module cdc_export import mailbox_pkg::*; #(
	parameter type payload_t = cmd_t
) (
	input logic clk,
	input logic arst_n,
	input payload_t data, // word to send, sampled on start
	input logic start, // one-cycle request, only while ready
	output logic ready, // high while no transfer is in flight
	output payload_t xfer_data, // held for the whole valid phase
	output logic xfer_valid,
	input logic xfer_ack // comes from the destination clock domain
);
	typedef enum logic [1:0] {
		st_idle,
		st_wait_ack,
		st_wait_release
	} state_t;

	state_t state;
	logic ack_q1; // first synchronizer stage, may go metastable
	logic ack_q2; // second stage, safe to use in this domain

	assign ready = (state == st_idle); // busy covers the whole four-phase sequence

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q1 <= 1'b0;
			ack_q2 <= 1'b0;
		end else begin
			ack_q1 <= xfer_ack;
			ack_q2 <= ack_q1;
		end
	end

	always_ff @(posedge clk) begin
		if (start && ready) begin
			xfer_data <= data; // settles long before valid is seen through the far synchronizer
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			xfer_valid <= 1'b0;
		end else begin
			case (state)
			st_idle: begin
				if (start) begin
					xfer_valid <= 1'b1;
					state <= st_wait_ack;
				end
			end
			st_wait_ack: begin
				if (ack_q2) begin // destination has copied the word
					xfer_valid <= 1'b0;
					state <= st_wait_release;
				end
			end
			st_wait_release: begin
				if (!ack_q2) begin // destination saw valid fall and released ack
					state <= st_idle;
				end
			end
			default: state <= st_idle;
			endcase
		end
	end

	// the far side may sample xfer_data at any point of the valid phase
	a_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
		xfer_valid |=> !xfer_valid || $stable(xfer_data));

	// the requester has to honour ready, a start while busy would be lost
	a_start_ready: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> ready);

endmodule

// ==== cdc_import.sv ====
`timescale 1ns/1ns

module cdc_import import mailbox_pkg::*; #(
	parameter type payload_t = cmd_t
) (
	input logic clk,
	input logic arst_n,
	input payload_t xfer_data, // stable while xfer_valid is high
	input logic xfer_valid, // comes from the source clock domain
	output logic xfer_ack,
	output payload_t data, // copy of the last word received
	output logic stb // one cycle, data is valid from here on
);
	typedef enum logic {
		st_load,
		st_acknowledge
	} state_t;

	state_t state;
	logic valid_q1; // first synchronizer stage
	logic valid_q2; // second stage, only this one feeds the FSM

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q1 <= 1'b0;
			valid_q2 <= 1'b0;
		end else begin
			valid_q1 <= xfer_valid;
			valid_q2 <= valid_q1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_load && valid_q2) begin
			data <= xfer_data; // source holds it until it sees our ack
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_load;
			xfer_ack <= 1'b0;
			stb <= 1'b0;
		end else begin
			stb <= 1'b0; // default low, pulses only on a fresh word
			case (state)
			st_load: begin
				if (valid_q2) begin
					stb <= 1'b1;
					state <= st_acknowledge;
				end
			end
			st_acknowledge: begin
				xfer_ack <= 1'b1; // raised one cycle after the strobe
				if (!valid_q2) begin // source has dropped valid, close the handshake
					xfer_ack <= 1'b0;
					state <= st_load;
				end
			end
			default: state <= st_load;
			endcase
		end
	end

	// a single transfer must never strobe twice, the FSM has to pass through ack first
	a_stb_single: assert property (@(posedge clk) disable iff (!arst_n)
		stb |=> !stb);

endmodule

// ==== mailbox_pkg.sv ====
package mailbox_pkg;

	localparam int unsigned axil_addr_w = 4; // byte address into the four-word register window
	localparam int unsigned axil_data_w = 32; // AXI4-Lite data bus width

	localparam logic [axil_addr_w-1:0] reg_cmd = 4'h0; // write only, opcode and argument
	localparam logic [axil_addr_w-1:0] reg_status = 4'h4; // read only, last status code
	localparam logic [axil_addr_w-1:0] reg_flags = 4'h8; // read only, bit 0 cmd_busy, bit 1 sts_new

	localparam logic [1:0] resp_okay = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;

	typedef struct packed {
		logic [7:0] opcode; // lands on wdata[23:16]
		logic [15:0] arg; // lands on wdata[15:0]
	} cmd_t;

	typedef struct packed {
		logic [15:0] code; // returned on rdata[15:0]
	} sts_t;

	typedef struct packed {
		logic [axil_addr_w-1:0] awaddr;
		logic awvalid;
		logic [axil_data_w-1:0] wdata;
		logic [axil_data_w/8-1:0] wstrb; // carried for bus completeness, full-word writes only
		logic wvalid;
		logic bready;
		logic [axil_addr_w-1:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic [axil_data_w-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
		logic arready;
	} axil_rsp_t;

endpackage

// ==== mailbox_regs.sv ====
`timescale 1ns/1ns

module mailbox_regs import mailbox_pkg::*; (
	input logic clk,
	input logic arst_n,
	input axil_req_t axil_req, // host requests, wstrb is ignored
	output axil_rsp_t axil_rsp,
	output cmd_t cmd, // held until the command crossing latches it
	output logic cmd_start, // one cycle after the accepted write
	input logic cmd_ready, // command crossing is idle
	input sts_t sts, // status word from the status crossing
	input logic sts_stb // one cycle, sts is fresh
);
	logic wr_fire; // address and data taken this cycle
	logic rd_fire; // read address taken this cycle
	logic cmd_busy;
	logic cmd_accept; // write goes out to the far side
	logic sts_new; // status captured but not yet read
	sts_t sts_q;
	logic bvalid;
	logic [1:0] bresp;
	logic rvalid;
	logic [1:0] rresp;
	logic [axil_data_w-1:0] rdata;

	// start is registered, so busy has to include its cycle as well as the crossing
	assign cmd_busy = !cmd_ready || cmd_start;

	assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid; // one response outstanding at most
	assign rd_fire = axil_req.arvalid && !rvalid;
	assign cmd_accept = wr_fire && (axil_req.awaddr == reg_cmd) && !cmd_busy;

	always_comb begin
		axil_rsp = '0;
		axil_rsp.awready = wr_fire; // address and data are taken together
		axil_rsp.wready = wr_fire;
		axil_rsp.bvalid = bvalid;
		axil_rsp.bresp = bresp;
		axil_rsp.arready = rd_fire;
		axil_rsp.rvalid = rvalid;
		axil_rsp.rresp = rresp;
		axil_rsp.rdata = rdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid <= 1'b0;
		end else if (wr_fire) begin
			bvalid <= 1'b1;
		end else if (axil_req.bready) begin
			bvalid <= 1'b0; // response taken by the host
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp <= cmd_accept ? resp_okay : resp_slverr; // busy CMD and bad address both fail
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_accept) begin
			cmd <= cmd_t'(axil_req.wdata[$bits(cmd_t)-1:0]); // upper byte of wdata is dropped
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd_start <= 1'b0;
		end else begin
			cmd_start <= cmd_accept; // cmd is loaded on the same edge
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sts_q <= '0; // a STATUS read before any status returns zero
			sts_new <= 1'b0;
		end else if (sts_stb) begin
			sts_q <= sts;
			sts_new <= 1'b1; // a new status wins over a read in the same cycle
		end else if (rd_fire && axil_req.araddr == reg_status) begin
			sts_new <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
		end else if (rd_fire) begin
			rvalid <= 1'b1;
		end else if (axil_req.rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= '0; // unused upper bits read as zero
			rresp <= resp_okay;
			case (axil_req.araddr)
			reg_status: rdata[$bits(sts_t)-1:0] <= sts_q;
			reg_flags: rdata[1:0] <= {sts_new, cmd_busy};
			default: rresp <= resp_slverr; // CMD is write only, the rest is unmapped
			endcase
		end
	end

endmodule

// ==== mailbox_tb.sv ====
`timescale 1ns/1ns

module mailbox_tb import mailbox_pkg::*; ();
	localparam int n_cmds = 12;
	localparam int n_sts = 6;
	localparam int n_trans = n_cmds + n_sts + 4; // plus the busy pair and the unmapped pair
	localparam int max_cycles = 40 * n_trans * 20;

	logic clk;
	logic far_clk;
	logic arst_n;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	cmd_t cmd_data;
	logic cmd_stb;
	sts_t sts_data;
	logic sts_stb;
	logic sts_ready;
	integer seed;
	int errors = 0;
	int sent = 0;
	int received = 0;
	int cycles = 0;
	int stall_max = 3; // longest bready/rready hold-off in clk cycles
	cmd_t exp_q[$]; // commands the far side still has to see
	cmd_t exp_head = '0; // front of exp_q, refreshed away from the far_clk rising edge
	logic exp_valid = 1'b0;

	tb_clock clock0 (.clk(clk), .far_clk(far_clk), .arst_n(arst_n));

	mailbox_top dut0 (
		.clk(clk), .far_clk(far_clk), .arst_n(arst_n),
		.axil_req(axil_req), .axil_rsp(axil_rsp),
		.cmd_data(cmd_data), .cmd_stb(cmd_stb),
		.sts_data(sts_data), .sts_stb(sts_stb), .sts_ready(sts_ready)
	);

	task automatic flag_error(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	always @(negedge far_clk) begin
		exp_valid = (exp_q.size() != 0);
		if (exp_valid) begin
			exp_head = exp_q[0];
		end
	end

	always @(posedge far_clk) begin
		if (arst_n && cmd_stb && exp_q.size() != 0) begin
			void'(exp_q.pop_front()); // the match itself is checked by a_cmd_match
			received++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d clk cycles", max_cycles);
			$display("test failed");
			$finish;
		end
	end

	// every strobe must carry the oldest command still expected, a stray strobe fails here too
	a_cmd_match: assert property (@(posedge far_clk) disable iff (!arst_n)
		cmd_stb |-> exp_valid && cmd_data == exp_head)
		else flag_error("cmd_stb with unexpected command");

	a_wr_pair: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.awready == axil_rsp.wready) // address and data are taken together
		else flag_error("awready and wready differ");

	// a write offered with no response pending is taken at once and answered next cycle
	a_wr_accept: assert property (@(posedge clk) disable iff (!arst_n)
		axil_req.awvalid && axil_req.wvalid && !axil_rsp.bvalid
		|-> axil_rsp.awready && axil_rsp.wready ##1 axil_rsp.bvalid)
		else flag_error("write not accepted or not answered next cycle");

	a_rd_accept: assert property (@(posedge clk) disable iff (!arst_n)
		axil_req.arvalid && !axil_rsp.rvalid |-> axil_rsp.arready ##1 axil_rsp.rvalid)
		else flag_error("read not accepted or not answered next cycle");

	a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
		else flag_error("write response changed while stalled");

	a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata)
		&& $stable(axil_rsp.rresp))
		else flag_error("read response changed while stalled");

	a_sts_busy: assert property (@(posedge far_clk) disable iff (!arst_n)
		sts_stb |-> sts_ready ##1 !sts_ready) // ready drops for the whole crossing
		else flag_error("sts_ready wrong around sts_stb");

	task automatic check(input logic ok, input string msg);
		assert (ok) else flag_error(msg);
	endtask

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int stall;
		@(negedge clk);
		axil_req.awaddr = addr;
		axil_req.wdata = data;
		axil_req.wstrb = '1;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid = 1'b1;
		@(negedge clk);
		while (!axil_rsp.bvalid) @(negedge clk); // bvalid only rises after the accept
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		resp = axil_rsp.bresp;
		stall = $unsigned($random(seed)) % (stall_max + 1);
		repeat (stall) @(negedge clk);
		axil_req.bready = 1'b1;
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int stall;
		@(negedge clk);
		axil_req.araddr = addr;
		axil_req.arvalid = 1'b1;
		@(negedge clk);
		while (!axil_rsp.rvalid) @(negedge clk);
		axil_req.arvalid = 1'b0;
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		stall = $unsigned($random(seed)) % (stall_max + 1);
		repeat (stall) @(negedge clk);
		axil_req.rready = 1'b1;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	task automatic poll_flags(input int bit_idx, input logic level);
		logic [31:0] flags;
		logic [1:0] resp;
		do begin
			axil_read(reg_flags, flags, resp);
			check(resp == resp_okay, "FLAGS read not OKAY");
		end while (flags[bit_idx] != level);
	endtask

	task automatic give_status(input logic [15:0] code);
		@(negedge far_clk);
		while (!sts_ready) @(negedge far_clk); // previous status still crossing
		sts_data.code = code;
		sts_stb = 1'b1;
		@(negedge far_clk);
		sts_stb = 1'b0;
	endtask

	initial begin
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [1:0] resp;
		logic [15:0] code;
		cmd_t exp;
		int i;
		seed = 32'hb20cc709;
		axil_req = '0;
		sts_data = '0;
		sts_stb = 1'b0;
		@(posedge arst_n);
		@(negedge clk);
		check(!axil_rsp.awready && !axil_rsp.wready && !axil_rsp.arready, "ready high after reset");
		check(!axil_rsp.bvalid && !axil_rsp.rvalid, "response valid after reset");
		check(!cmd_stb && sts_ready, "far side outputs wrong after reset");
		axil_read(reg_flags, rdata, resp);
		check(rdata == 32'h0 && resp == resp_okay, "FLAGS not zero after reset");

		for (i = 0; i < n_cmds; i++) begin
			wdata = $random(seed);
			exp.opcode = wdata[23:16]; // opcode sits above the 16-bit argument
			exp.arg = wdata[15:0];
			exp_q.push_back(exp); // crossing is idle, so the write must go through
			axil_write(reg_cmd, wdata, resp);
			check(resp == resp_okay, "CMD write while idle not OKAY");
			sent++;
			poll_flags(0, 1'b0);
		end

		stall_max = 0; // keep the second write well inside the busy window
		wdata = $random(seed);
		exp.opcode = wdata[23:16];
		exp.arg = wdata[15:0];
		exp_q.push_back(exp);
		axil_write(reg_cmd, wdata, resp);
		check(resp == resp_okay, "first CMD write of busy pair not OKAY");
		sent++;
		axil_read(reg_flags, rdata, resp);
		check(rdata[0] == 1'b1, "FLAGS does not show cmd_busy");
		axil_write(reg_cmd, $random(seed), resp);
		check(resp == resp_slverr, "CMD write while busy not SLVERR");
		stall_max = 3;
		poll_flags(0, 1'b0);

		for (i = 0; i < n_sts; i++) begin
			code = $random(seed);
			give_status(code);
			poll_flags(1, 1'b1);
			axil_read(reg_status, rdata, resp);
			check(rdata == {16'h0, code} && resp == resp_okay, "STATUS code mismatch");
			axil_read(reg_flags, rdata, resp);
			check(rdata[1] == 1'b0, "sts_new not cleared by STATUS read");
		end

		axil_write(4'hc, $random(seed), resp);
		check(resp == resp_slverr, "write to 0xC not SLVERR");
		axil_read(4'hc, rdata, resp);
		check(resp == resp_slverr && rdata == 32'h0, "read of 0xC not SLVERR with zero");

		check(exp_q.size() == 0, "accepted command never reached the far side");
		$display("commands sent %0d, received %0d, statuses %0d, errors %0d",
			sent, received, n_sts, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== mailbox_top.sv ====
`timescale 1ns/1ns

module mailbox_top import mailbox_pkg::*; (
	input logic clk, // host and register block clock
	input logic far_clk, // far side clock, unrelated to clk
	input logic arst_n, // shared by both domains
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output cmd_t cmd_data, // far side, valid from cmd_stb on
	output logic cmd_stb,
	input sts_t sts_data, // far side, sampled on sts_stb
	input logic sts_stb, // only while sts_ready is high
	output logic sts_ready
);
	cmd_t cmd_word; // command held by the register block
	logic cmd_start;
	logic cmd_ready;
	cmd_t cmd_xfer_data; // clk domain, crosses to far_clk
	logic cmd_xfer_valid;
	logic cmd_xfer_ack; // far_clk domain, crosses back to clk
	sts_t sts_xfer_data; // far_clk domain, crosses to clk
	logic sts_xfer_valid;
	logic sts_xfer_ack; // clk domain, crosses back to far_clk
	sts_t sts_word;
	logic sts_word_stb;

	mailbox_regs regs0 (
		.clk(clk),
		.arst_n(arst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.cmd(cmd_word),
		.cmd_start(cmd_start),
		.cmd_ready(cmd_ready),
		.sts(sts_word),
		.sts_stb(sts_word_stb)
	);

	cdc_export #(.payload_t(cmd_t)) cmd_tx (
		.clk(clk),
		.arst_n(arst_n),
		.data(cmd_word),
		.start(cmd_start),
		.ready(cmd_ready),
		.xfer_data(cmd_xfer_data),
		.xfer_valid(cmd_xfer_valid),
		.xfer_ack(cmd_xfer_ack)
	);

	cdc_import #(.payload_t(cmd_t)) cmd_rx (
		.clk(far_clk),
		.arst_n(arst_n),
		.xfer_data(cmd_xfer_data),
		.xfer_valid(cmd_xfer_valid),
		.xfer_ack(cmd_xfer_ack),
		.data(cmd_data),
		.stb(cmd_stb)
	);

	cdc_export #(.payload_t(sts_t)) sts_tx (
		.clk(far_clk),
		.arst_n(arst_n),
		.data(sts_data),
		.start(sts_stb),
		.ready(sts_ready),
		.xfer_data(sts_xfer_data),
		.xfer_valid(sts_xfer_valid),
		.xfer_ack(sts_xfer_ack)
	);

	cdc_import #(.payload_t(sts_t)) sts_rx (
		.clk(clk),
		.arst_n(arst_n),
		.xfer_data(sts_xfer_data),
		.xfer_valid(sts_xfer_valid),
		.xfer_ack(sts_xfer_ack),
		.data(sts_word),
		.stb(sts_word_stb)
	);

endmodule

// ==== src.f ====
mailbox_pkg.sv
cdc_export.sv
cdc_import.sv
mailbox_regs.sv
mailbox_top.sv
tb_clock.sv
mailbox_tb.sv

// ==== tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output logic clk, // host side, 8 ns
	output logic far_clk, // far side, 14 ns, no fixed phase to clk
	output logic arst_n
);
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		far_clk = 1'b0;
		forever #7 far_clk = ~far_clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk); // release away from any active clk edge
		arst_n = 1'b1;
	end

endmodule
